// ==== src/isa_pkg.sv ====
package isa_pkg;

    localparam int OP_W    = 6;
    localparam int FUNCT_W = 6;
    localparam int RT_W    = 5;

    // Primary opcode field, instr[31:26]
    typedef enum logic [OP_W-1:0] {
        OP_SPECIAL = 6'b000000, OP_REGIMM = 6'b000001,
        OP_J       = 6'b000010, OP_JAL    = 6'b000011,
        OP_BEQ     = 6'b000100, OP_BNE    = 6'b000101,
        OP_BLEZ    = 6'b000110, OP_BGTZ   = 6'b000111,
        OP_ADDI    = 6'b001000, OP_ADDIU  = 6'b001001,
        OP_SLTI    = 6'b001010, OP_SLTIU  = 6'b001011,
        OP_ANDI    = 6'b001100, OP_ORI    = 6'b001101,
        OP_XORI    = 6'b001110, OP_LUI    = 6'b001111,
        OP_LB      = 6'b100000, OP_LH     = 6'b100001,
        OP_LW      = 6'b100011, OP_LBU    = 6'b100100,
        OP_LHU     = 6'b100101, OP_SB     = 6'b101000,
        OP_SH      = 6'b101001, OP_SW     = 6'b101011
    } opcode_e;

    // Function field of SPECIAL, instr[5:0]
    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL   = 6'b000000, FN_SRL   = 6'b000010, FN_SRA  = 6'b000011,
        FN_SLLV  = 6'b000100, FN_SRLV  = 6'b000110, FN_SRAV = 6'b000111,
        FN_JR    = 6'b001000, FN_JALR  = 6'b001001,
        FN_MFHI  = 6'b010000, FN_MTHI  = 6'b010001,
        FN_MFLO  = 6'b010010, FN_MTLO  = 6'b010011,
        FN_MULT  = 6'b011000, FN_MULTU = 6'b011001,
        FN_DIV   = 6'b011010, FN_DIVU  = 6'b011011,
        FN_ADD   = 6'b100000, FN_ADDU  = 6'b100001,
        FN_SUB   = 6'b100010, FN_SUBU  = 6'b100011,
        FN_AND   = 6'b100100, FN_OR    = 6'b100101,
        FN_XOR   = 6'b100110, FN_NOR   = 6'b100111,
        FN_SLT   = 6'b101010, FN_SLTU  = 6'b101011
    } funct_e;

    // rt field of REGIMM selects the branch
    typedef enum logic [RT_W-1:0] {
        RI_BLTZ   = 5'b00000,
        RI_BGEZ   = 5'b00001,
        RI_BLTZAL = 5'b10000,
        RI_BGEZAL = 5'b10001
    } regimm_e;

endpackage

// ==== src/ctrl_pkg.sv ====
package ctrl_pkg;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SUB  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_AND  = 3'b100,
        ALU_NOR  = 3'b101,
        ALU_OR   = 3'b110,
        ALU_XOR  = 3'b111
    } alu_op_e;

    typedef enum logic [1:0] {
        SFT_LUI = 2'b00,
        SFT_SLL = 2'b01,
        SFT_SRA = 2'b10,
        SFT_SRL = 2'b11
    } shift_op_e;

    typedef enum logic [1:0] {
        OUT_ALU = 2'b00, OUT_SHIFT = 2'b01, OUT_HI = 2'b10, OUT_LO = 2'b11
    } out_sel_e;

    typedef enum logic [1:0] {
        DST_RT = 2'b00, DST_RD = 2'b01, DST_RA = 2'b10
    } reg_dst_e;

    typedef enum logic [2:0] {
        BR_EQ    = 3'b000, BR_NE  = 3'b001, BR_GEZ   = 3'b010, BR_GTZ   = 3'b011,
        BR_LEZ   = 3'b100, BR_LTZ = 3'b101, BR_GEZAL = 3'b110, BR_LTZAL = 3'b111
    } branch_cond_e;

    typedef enum logic [1:0] {
        JMP_J = 2'b00, JMP_JR = 2'b01, JMP_JAL = 2'b10, JMP_JALR = 2'b11
    } jump_kind_e;

    // HI/LO write source
    typedef enum logic [1:0] {
        HL_MUL = 2'b00, HL_DIV = 2'b01, HL_RS = 2'b10
    } hilo_sel_e;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00, SZ_HALF = 2'b01, SZ_WORD = 2'b10
    } mem_size_e;

    // All zero is a bubble
    typedef struct packed {
        alu_op_e      alu_op;
        logic         alu_srcb_rt;
        shift_op_e    shift_op;
        logic         shift_amt_rs;      // Shift amount from rs, else shamt
        logic         shift_srca_imm;    // LUI shifts the immediate
        out_sel_e     out_sel;
        reg_dst_e     reg_dst;
        logic         reg_write;
        logic         link;
        logic         imm_sign;
        logic         is_branch;
        branch_cond_e branch_cond;
        logic         is_jump;
        jump_kind_e   jump_kind;
        logic         mul_sign;
        logic         div_en;
        logic         div_sign;
        hilo_sel_e    hi_sel;
        hilo_sel_e    lo_sel;
        logic         hi_wen;
        logic         lo_wen;
        logic         mem_req;
        logic         mem_write;
        mem_size_e    mem_size;
        logic         rdata_sign;
        logic         mem_to_reg;
        logic         reserved;
    } ctrl_word_t;

    localparam int CTRL_W = $bits(ctrl_word_t);

endpackage

// ==== src/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
    input  logic [isa_pkg::OP_W-1:0]    op,
    input  logic [isa_pkg::FUNCT_W-1:0] funct,
    input  logic [isa_pkg::RT_W-1:0]    rt,
    input  logic                        rs_eq_rt,
    input  logic                        rs_gt_zero,
    input  logic                        rs_eq_zero,
    output ctrl_pkg::ctrl_word_t        ctrl,
    output logic                        branch_taken
);

    logic cond_met;

    // R-type takes rt as operand B and writes rd; I-type writes rt
    function automatic ctrl_pkg::ctrl_word_t alu_word(input ctrl_pkg::alu_op_e alu_op,
                                                      input logic rtype,
                                                      input logic sign);
        ctrl_pkg::ctrl_word_t w;
        w = '0;
        w.alu_op = alu_op;
        w.alu_srcb_rt = rtype;
        w.reg_write = 1'b1;
        w.reg_dst = rtype ? ctrl_pkg::DST_RD : ctrl_pkg::DST_RT;
        w.imm_sign = sign;
        return w;
    endfunction

    function automatic ctrl_pkg::ctrl_word_t shift_word(input ctrl_pkg::shift_op_e shift_op,
                                                        input logic by_rs);
        ctrl_pkg::ctrl_word_t w;
        w = '0;
        w.shift_op = shift_op;
        w.shift_amt_rs = by_rs;
        w.out_sel = ctrl_pkg::OUT_SHIFT;
        w.reg_write = 1'b1;
        w.reg_dst = ctrl_pkg::DST_RD;
        return w;
    endfunction

    function automatic ctrl_pkg::ctrl_word_t mem_word(input ctrl_pkg::mem_size_e size,
                                                      input logic write,
                                                      input logic sign);
        ctrl_pkg::ctrl_word_t w;
        w = '0;
        w.mem_req = 1'b1;
        w.mem_write = write;
        w.mem_size = size;
        w.imm_sign = 1'b1;                  // Address offset is sign extended
        w.reg_write = !write;
        w.mem_to_reg = !write;
        w.rdata_sign = sign;
        return w;
    endfunction

    function automatic ctrl_pkg::ctrl_word_t branch_word(input ctrl_pkg::branch_cond_e cond,
                                                         input logic link);
        ctrl_pkg::ctrl_word_t w;
        w = '0;
        w.is_branch = 1'b1;
        w.branch_cond = cond;
        w.link = link;
        w.reg_write = link;
        w.reg_dst = link ? ctrl_pkg::DST_RA : ctrl_pkg::DST_RT;
        return w;
    endfunction

    function automatic ctrl_pkg::ctrl_word_t jump_word(input ctrl_pkg::jump_kind_e kind);
        ctrl_pkg::ctrl_word_t w;
        w = '0;
        w.is_jump = 1'b1;
        w.jump_kind = kind;
        w.link = (kind == ctrl_pkg::JMP_JAL) || (kind == ctrl_pkg::JMP_JALR);
        w.reg_write = w.link;
        w.reg_dst = (kind == ctrl_pkg::JMP_JAL) ? ctrl_pkg::DST_RA : ctrl_pkg::DST_RD;
        return w;
    endfunction

    always_comb
    begin
        ctrl = '0;
        case (op)
            isa_pkg::OP_SPECIAL:
            begin
                case (funct)
                    isa_pkg::FN_ADD, isa_pkg::FN_ADDU: ctrl = alu_word(ctrl_pkg::ALU_ADD, 1'b1, 1'b0);
                    isa_pkg::FN_SUB, isa_pkg::FN_SUBU: ctrl = alu_word(ctrl_pkg::ALU_SUB, 1'b1, 1'b0);
                    isa_pkg::FN_SLT:  ctrl = alu_word(ctrl_pkg::ALU_SLT, 1'b1, 1'b0);
                    isa_pkg::FN_SLTU: ctrl = alu_word(ctrl_pkg::ALU_SLTU, 1'b1, 1'b0);
                    isa_pkg::FN_AND:  ctrl = alu_word(ctrl_pkg::ALU_AND, 1'b1, 1'b0);
                    isa_pkg::FN_OR:   ctrl = alu_word(ctrl_pkg::ALU_OR, 1'b1, 1'b0);
                    isa_pkg::FN_XOR:  ctrl = alu_word(ctrl_pkg::ALU_XOR, 1'b1, 1'b0);
                    isa_pkg::FN_NOR:  ctrl = alu_word(ctrl_pkg::ALU_NOR, 1'b1, 1'b0);
                    isa_pkg::FN_SLL:  ctrl = shift_word(ctrl_pkg::SFT_SLL, 1'b0);
                    isa_pkg::FN_SRL:  ctrl = shift_word(ctrl_pkg::SFT_SRL, 1'b0);
                    isa_pkg::FN_SRA:  ctrl = shift_word(ctrl_pkg::SFT_SRA, 1'b0);
                    isa_pkg::FN_SLLV: ctrl = shift_word(ctrl_pkg::SFT_SLL, 1'b1);
                    isa_pkg::FN_SRLV: ctrl = shift_word(ctrl_pkg::SFT_SRL, 1'b1);
                    isa_pkg::FN_SRAV: ctrl = shift_word(ctrl_pkg::SFT_SRA, 1'b1);
                    isa_pkg::FN_JR:   ctrl = jump_word(ctrl_pkg::JMP_JR);
                    isa_pkg::FN_JALR: ctrl = jump_word(ctrl_pkg::JMP_JALR);
                    isa_pkg::FN_MFHI, isa_pkg::FN_MFLO:
                    begin
                        ctrl.out_sel = (funct == isa_pkg::FN_MFHI) ? ctrl_pkg::OUT_HI
                                                                    : ctrl_pkg::OUT_LO;
                        ctrl.reg_write = 1'b1;
                        ctrl.reg_dst = ctrl_pkg::DST_RD;
                    end
                    isa_pkg::FN_MTHI:
                    begin
                        ctrl.hi_sel = ctrl_pkg::HL_RS;
                        ctrl.hi_wen = 1'b1;
                    end
                    isa_pkg::FN_MTLO:
                    begin
                        ctrl.lo_sel = ctrl_pkg::HL_RS;
                        ctrl.lo_wen = 1'b1;
                    end
                    isa_pkg::FN_MULT, isa_pkg::FN_MULTU:
                    begin
                        ctrl.mul_sign = (funct == isa_pkg::FN_MULT);
                        ctrl.hi_sel = ctrl_pkg::HL_MUL;
                        ctrl.lo_sel = ctrl_pkg::HL_MUL;
                        ctrl.hi_wen = 1'b1;
                        ctrl.lo_wen = 1'b1;
                    end
                    isa_pkg::FN_DIV, isa_pkg::FN_DIVU:
                    begin
                        ctrl.div_en = 1'b1;
                        ctrl.div_sign = (funct == isa_pkg::FN_DIV);
                        ctrl.hi_sel = ctrl_pkg::HL_DIV;    // Remainder
                        ctrl.lo_sel = ctrl_pkg::HL_DIV;    // Quotient
                        ctrl.hi_wen = 1'b1;
                        ctrl.lo_wen = 1'b1;
                    end
                    default: ctrl.reserved = 1'b1;         // BREAK and SYSCALL land here
                endcase
            end
            isa_pkg::OP_REGIMM:
            begin
                case (rt)
                    isa_pkg::RI_BLTZ:   ctrl = branch_word(ctrl_pkg::BR_LTZ, 1'b0);
                    isa_pkg::RI_BGEZ:   ctrl = branch_word(ctrl_pkg::BR_GEZ, 1'b0);
                    isa_pkg::RI_BLTZAL: ctrl = branch_word(ctrl_pkg::BR_LTZAL, 1'b1);
                    isa_pkg::RI_BGEZAL: ctrl = branch_word(ctrl_pkg::BR_GEZAL, 1'b1);
                    default:            ctrl.reserved = 1'b1;
                endcase
            end
            isa_pkg::OP_BEQ:   ctrl = branch_word(ctrl_pkg::BR_EQ, 1'b0);
            isa_pkg::OP_BNE:   ctrl = branch_word(ctrl_pkg::BR_NE, 1'b0);
            isa_pkg::OP_BLEZ:  ctrl = branch_word(ctrl_pkg::BR_LEZ, 1'b0);
            isa_pkg::OP_BGTZ:  ctrl = branch_word(ctrl_pkg::BR_GTZ, 1'b0);
            isa_pkg::OP_J:     ctrl = jump_word(ctrl_pkg::JMP_J);
            isa_pkg::OP_JAL:   ctrl = jump_word(ctrl_pkg::JMP_JAL);
            isa_pkg::OP_ADDI, isa_pkg::OP_ADDIU: ctrl = alu_word(ctrl_pkg::ALU_ADD, 1'b0, 1'b1);
            isa_pkg::OP_SLTI:  ctrl = alu_word(ctrl_pkg::ALU_SLT, 1'b0, 1'b1);
            isa_pkg::OP_SLTIU: ctrl = alu_word(ctrl_pkg::ALU_SLTU, 1'b0, 1'b1);
            isa_pkg::OP_ANDI:  ctrl = alu_word(ctrl_pkg::ALU_AND, 1'b0, 1'b0);
            isa_pkg::OP_ORI:   ctrl = alu_word(ctrl_pkg::ALU_OR, 1'b0, 1'b0);
            isa_pkg::OP_XORI:  ctrl = alu_word(ctrl_pkg::ALU_XOR, 1'b0, 1'b0);
            isa_pkg::OP_LUI:
            begin
                ctrl.shift_op = ctrl_pkg::SFT_LUI;
                ctrl.shift_srca_imm = 1'b1;
                ctrl.out_sel = ctrl_pkg::OUT_SHIFT;
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst = ctrl_pkg::DST_RT;
            end
            isa_pkg::OP_LB:    ctrl = mem_word(ctrl_pkg::SZ_BYTE, 1'b0, 1'b1);
            isa_pkg::OP_LH:    ctrl = mem_word(ctrl_pkg::SZ_HALF, 1'b0, 1'b1);
            isa_pkg::OP_LW:    ctrl = mem_word(ctrl_pkg::SZ_WORD, 1'b0, 1'b1);
            isa_pkg::OP_LBU:   ctrl = mem_word(ctrl_pkg::SZ_BYTE, 1'b0, 1'b0);
            isa_pkg::OP_LHU:   ctrl = mem_word(ctrl_pkg::SZ_HALF, 1'b0, 1'b0);
            isa_pkg::OP_SB:    ctrl = mem_word(ctrl_pkg::SZ_BYTE, 1'b1, 1'b0);
            isa_pkg::OP_SH:    ctrl = mem_word(ctrl_pkg::SZ_HALF, 1'b1, 1'b0);
            isa_pkg::OP_SW:    ctrl = mem_word(ctrl_pkg::SZ_WORD, 1'b1, 1'b0);
            default:           ctrl.reserved = 1'b1;   // COP0 included
        endcase
    end

    // rs compared against zero for the REGIMM and BLEZ/BGTZ forms
    always_comb
    begin
        cond_met = 1'b0;
        case (ctrl.branch_cond)
            ctrl_pkg::BR_EQ:                    cond_met = rs_eq_rt;
            ctrl_pkg::BR_NE:                    cond_met = !rs_eq_rt;
            ctrl_pkg::BR_GEZ, ctrl_pkg::BR_GEZAL: cond_met = rs_gt_zero || rs_eq_zero;
            ctrl_pkg::BR_GTZ:                   cond_met = rs_gt_zero;
            ctrl_pkg::BR_LEZ:                   cond_met = !rs_gt_zero;
            ctrl_pkg::BR_LTZ, ctrl_pkg::BR_LTZAL: cond_met = !rs_gt_zero && !rs_eq_zero;
            default:                            cond_met = 1'b0;
        endcase
    end

    assign branch_taken = ctrl.is_branch && cond_met;

endmodule

// ==== src/ctrl_pipeline.sv ====
`timescale 1ns/1ps

module ctrl_pipeline (
    input  logic                 clk,
    input  logic                 arst_n,
    input  ctrl_pkg::ctrl_word_t d_ctrl,
    input  logic                 stall_e,
    input  logic                 stall_m,
    input  logic                 stall_w,
    input  logic                 flush_e,
    input  logic                 flush_m,
    input  logic                 flush_w,
    output ctrl_pkg::ctrl_word_t e_ctrl,
    output ctrl_pkg::ctrl_word_t m_ctrl,
    output ctrl_pkg::ctrl_word_t w_ctrl
);

    // Execute stage
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            e_ctrl <= '0;
        else if (flush_e)
            e_ctrl <= '0;        // Flush beats stall
        else if (!stall_e)
            e_ctrl <= d_ctrl;
    end

    // Memory stage
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            m_ctrl <= '0;
        else if (flush_m)
            m_ctrl <= '0;
        else if (!stall_m)
            m_ctrl <= e_ctrl;    // Copies a held E word again
    end

    // Writeback stage
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            w_ctrl <= '0;
        else if (flush_w)
            w_ctrl <= '0;
        else if (!stall_w)
            w_ctrl <= m_ctrl;
    end

endmodule

// ==== src/pipeline_controller.sv ====
`timescale 1ns/1ps

module pipeline_controller (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [isa_pkg::OP_W-1:0]    op,
    input  logic [isa_pkg::FUNCT_W-1:0] funct,
    input  logic [isa_pkg::RT_W-1:0]    rt,
    input  logic                        rs_eq_rt,
    input  logic                        rs_gt_zero,
    input  logic                        rs_eq_zero,
    input  logic                        stall_e,
    input  logic                        stall_m,
    input  logic                        stall_w,
    input  logic                        flush_e,
    input  logic                        flush_m,
    input  logic                        flush_w,
    output ctrl_pkg::ctrl_word_t        d_ctrl,
    output ctrl_pkg::ctrl_word_t        e_ctrl,
    output ctrl_pkg::ctrl_word_t        m_ctrl,
    output ctrl_pkg::ctrl_word_t        w_ctrl,
    output logic                        branch_taken
);

    decode_unit u_decode (
        .op           (op),
        .funct        (funct),
        .rt           (rt),
        .rs_eq_rt     (rs_eq_rt),
        .rs_gt_zero   (rs_gt_zero),
        .rs_eq_zero   (rs_eq_zero),
        .ctrl         (d_ctrl),
        .branch_taken (branch_taken)     // Resolved in decode
    );

    ctrl_pipeline u_pipe (
        .clk     (clk),
        .arst_n  (arst_n),
        .d_ctrl  (d_ctrl),
        .stall_e (stall_e),
        .stall_m (stall_m),
        .stall_w (stall_w),
        .flush_e (flush_e),
        .flush_m (flush_m),
        .flush_w (flush_w),
        .e_ctrl  (e_ctrl),
        .m_ctrl  (m_ctrl),
        .w_ctrl  (w_ctrl)
    );

endmodule

// ==== verif/tb_pipeline_controller.sv ====
`timescale 1ns/1ps

module tb_pipeline_controller;

    localparam int RST_CYCLES = 4;
    localparam int N_TEST     = 600;
    localparam int N_SWEEP    = 54;                         // 24 opcodes, 26 functions, 4 REGIMM
    localparam int FREE_RUN   = 200;                        // No stall or flush before this
    localparam int MAX_CYCLES = (RST_CYCLES + N_TEST) * 5 / 3;

    localparam ctrl_pkg::ctrl_word_t BUBBLE = '0;

    localparam logic [5:0] OP_TAB [24] = '{
        isa_pkg::OP_SPECIAL, isa_pkg::OP_REGIMM, isa_pkg::OP_J,     isa_pkg::OP_JAL,
        isa_pkg::OP_BEQ,     isa_pkg::OP_BNE,    isa_pkg::OP_BLEZ,  isa_pkg::OP_BGTZ,
        isa_pkg::OP_ADDI,    isa_pkg::OP_ADDIU,  isa_pkg::OP_SLTI,  isa_pkg::OP_SLTIU,
        isa_pkg::OP_ANDI,    isa_pkg::OP_ORI,    isa_pkg::OP_XORI,  isa_pkg::OP_LUI,
        isa_pkg::OP_LB,      isa_pkg::OP_LH,     isa_pkg::OP_LW,    isa_pkg::OP_LBU,
        isa_pkg::OP_LHU,     isa_pkg::OP_SB,     isa_pkg::OP_SH,    isa_pkg::OP_SW
    };

    localparam logic [5:0] FN_TAB [26] = '{
        isa_pkg::FN_SLL,  isa_pkg::FN_SRL,   isa_pkg::FN_SRA,  isa_pkg::FN_SLLV,
        isa_pkg::FN_SRLV, isa_pkg::FN_SRAV,  isa_pkg::FN_JR,   isa_pkg::FN_JALR,
        isa_pkg::FN_MFHI, isa_pkg::FN_MTHI,  isa_pkg::FN_MFLO, isa_pkg::FN_MTLO,
        isa_pkg::FN_MULT, isa_pkg::FN_MULTU, isa_pkg::FN_DIV,  isa_pkg::FN_DIVU,
        isa_pkg::FN_ADD,  isa_pkg::FN_ADDU,  isa_pkg::FN_SUB,  isa_pkg::FN_SUBU,
        isa_pkg::FN_AND,  isa_pkg::FN_OR,    isa_pkg::FN_XOR,  isa_pkg::FN_NOR,
        isa_pkg::FN_SLT,  isa_pkg::FN_SLTU
    };

    localparam logic [4:0] RI_TAB [4] = '{
        isa_pkg::RI_BLTZ, isa_pkg::RI_BGEZ, isa_pkg::RI_BLTZAL, isa_pkg::RI_BGEZAL
    };

    logic clk;
    logic arst_n;
    logic [isa_pkg::OP_W-1:0] op;
    logic [isa_pkg::FUNCT_W-1:0] funct;
    logic [isa_pkg::RT_W-1:0] rt;
    logic rs_eq_rt, rs_gt_zero, rs_eq_zero;
    logic stall_e, stall_m, stall_w;
    logic flush_e, flush_m, flush_w;
    ctrl_pkg::ctrl_word_t d_ctrl, e_ctrl, m_ctrl, w_ctrl;
    logic branch_taken;

    ctrl_pkg::ctrl_word_t exp_d, exp_e, exp_m, exp_w;       // Shadow pipeline
    logic exp_taken;
    logic [31:0] seed;
    int cycles;

    pipeline_controller dut_i (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Upper LCG bits only, the low ones repeat quickly
    function automatic int unsigned pick(input int unsigned n);
        logic [31:0] r;
        r = lcg_next();
        return {16'd0, r[31:16]} % n;
    endfunction

    function automatic ctrl_pkg::ctrl_word_t ref_decode(
        input logic [isa_pkg::OP_W-1:0] op_v, input logic [isa_pkg::FUNCT_W-1:0] fn_v,
        input logic [isa_pkg::RT_W-1:0] rt_v, input logic eq, input logic gt,
        input logic ez, output logic taken);
        ctrl_pkg::ctrl_word_t w;
        logic cond;
        w = BUBBLE;
        cond = 1'b0;
        case (op_v)
            isa_pkg::OP_SPECIAL:
            begin
                case (fn_v)
                    isa_pkg::FN_ADD, isa_pkg::FN_ADDU, isa_pkg::FN_SUB, isa_pkg::FN_SUBU,
                    isa_pkg::FN_SLT, isa_pkg::FN_SLTU, isa_pkg::FN_AND, isa_pkg::FN_OR,
                    isa_pkg::FN_XOR, isa_pkg::FN_NOR:
                    begin
                        case (fn_v)
                            isa_pkg::FN_SUB, isa_pkg::FN_SUBU: w.alu_op = ctrl_pkg::ALU_SUB;
                            isa_pkg::FN_SLT:  w.alu_op = ctrl_pkg::ALU_SLT;
                            isa_pkg::FN_SLTU: w.alu_op = ctrl_pkg::ALU_SLTU;
                            isa_pkg::FN_AND:  w.alu_op = ctrl_pkg::ALU_AND;
                            isa_pkg::FN_OR:   w.alu_op = ctrl_pkg::ALU_OR;
                            isa_pkg::FN_XOR:  w.alu_op = ctrl_pkg::ALU_XOR;
                            isa_pkg::FN_NOR:  w.alu_op = ctrl_pkg::ALU_NOR;
                            default:          w.alu_op = ctrl_pkg::ALU_ADD;
                        endcase
                        w.alu_srcb_rt = 1'b1;
                        w.reg_write = 1'b1;
                        w.reg_dst = ctrl_pkg::DST_RD;
                    end
                    isa_pkg::FN_SLL, isa_pkg::FN_SRL, isa_pkg::FN_SRA,
                    isa_pkg::FN_SLLV, isa_pkg::FN_SRLV, isa_pkg::FN_SRAV:
                    begin
                        case (fn_v[1:0])
                            2'b00:   w.shift_op = ctrl_pkg::SFT_SLL;
                            2'b10:   w.shift_op = ctrl_pkg::SFT_SRL;
                            default: w.shift_op = ctrl_pkg::SFT_SRA;
                        endcase
                        w.shift_amt_rs = fn_v[2];                // Variable forms
                        w.out_sel = ctrl_pkg::OUT_SHIFT;
                        w.reg_write = 1'b1;
                        w.reg_dst = ctrl_pkg::DST_RD;
                    end
                    isa_pkg::FN_JR, isa_pkg::FN_JALR:
                    begin
                        w.is_jump = 1'b1;
                        w.jump_kind = fn_v[0] ? ctrl_pkg::JMP_JALR : ctrl_pkg::JMP_JR;
                        w.link = fn_v[0];
                        w.reg_write = fn_v[0];
                        w.reg_dst = ctrl_pkg::DST_RD;
                    end
                    isa_pkg::FN_MFHI, isa_pkg::FN_MFLO:
                    begin
                        w.out_sel = fn_v[1] ? ctrl_pkg::OUT_LO : ctrl_pkg::OUT_HI;
                        w.reg_write = 1'b1;
                        w.reg_dst = ctrl_pkg::DST_RD;
                    end
                    isa_pkg::FN_MTHI, isa_pkg::FN_MTLO:
                    begin
                        w.hi_sel = fn_v[1] ? ctrl_pkg::HL_MUL : ctrl_pkg::HL_RS;
                        w.lo_sel = fn_v[1] ? ctrl_pkg::HL_RS : ctrl_pkg::HL_MUL;
                        w.hi_wen = !fn_v[1];
                        w.lo_wen = fn_v[1];
                    end
                    isa_pkg::FN_MULT, isa_pkg::FN_MULTU, isa_pkg::FN_DIV, isa_pkg::FN_DIVU:
                    begin
                        w.div_en = fn_v[1];
                        w.mul_sign = !fn_v[1] && !fn_v[0];
                        w.div_sign = fn_v[1] && !fn_v[0];
                        w.hi_sel = fn_v[1] ? ctrl_pkg::HL_DIV : ctrl_pkg::HL_MUL;
                        w.lo_sel = fn_v[1] ? ctrl_pkg::HL_DIV : ctrl_pkg::HL_MUL;
                        w.hi_wen = 1'b1;
                        w.lo_wen = 1'b1;
                    end
                    default: w.reserved = 1'b1;
                endcase
            end
            isa_pkg::OP_REGIMM:
            begin
                if (rt_v[3:1] == 3'b000)
                begin
                    case ({rt_v[4], rt_v[0]})
                        2'b00:   w.branch_cond = ctrl_pkg::BR_LTZ;
                        2'b01:   w.branch_cond = ctrl_pkg::BR_GEZ;
                        2'b10:   w.branch_cond = ctrl_pkg::BR_LTZAL;
                        default: w.branch_cond = ctrl_pkg::BR_GEZAL;
                    endcase
                    w.is_branch = 1'b1;
                    w.link = rt_v[4];
                    w.reg_write = rt_v[4];
                    w.reg_dst = rt_v[4] ? ctrl_pkg::DST_RA : ctrl_pkg::DST_RT;
                end
                else
                    w.reserved = 1'b1;
            end
            isa_pkg::OP_BEQ, isa_pkg::OP_BNE, isa_pkg::OP_BLEZ, isa_pkg::OP_BGTZ:
            begin
                case (op_v[1:0])
                    2'b00:   w.branch_cond = ctrl_pkg::BR_EQ;
                    2'b01:   w.branch_cond = ctrl_pkg::BR_NE;
                    2'b10:   w.branch_cond = ctrl_pkg::BR_LEZ;
                    default: w.branch_cond = ctrl_pkg::BR_GTZ;
                endcase
                w.is_branch = 1'b1;
            end
            isa_pkg::OP_J, isa_pkg::OP_JAL:
            begin
                w.is_jump = 1'b1;
                w.jump_kind = op_v[0] ? ctrl_pkg::JMP_JAL : ctrl_pkg::JMP_J;
                w.link = op_v[0];
                w.reg_write = op_v[0];
                w.reg_dst = op_v[0] ? ctrl_pkg::DST_RA : ctrl_pkg::DST_RD;
            end
            isa_pkg::OP_ADDI, isa_pkg::OP_ADDIU, isa_pkg::OP_SLTI, isa_pkg::OP_SLTIU,
            isa_pkg::OP_ANDI, isa_pkg::OP_ORI, isa_pkg::OP_XORI:
            begin
                case (op_v[2:0])
                    3'b010:  w.alu_op = ctrl_pkg::ALU_SLT;
                    3'b011:  w.alu_op = ctrl_pkg::ALU_SLTU;
                    3'b100:  w.alu_op = ctrl_pkg::ALU_AND;
                    3'b101:  w.alu_op = ctrl_pkg::ALU_OR;
                    3'b110:  w.alu_op = ctrl_pkg::ALU_XOR;
                    default: w.alu_op = ctrl_pkg::ALU_ADD;
                endcase
                w.imm_sign = !op_v[2];                           // Logic ops zero extend
                w.reg_write = 1'b1;
                w.reg_dst = ctrl_pkg::DST_RT;
            end
            isa_pkg::OP_LUI:
            begin
                w.shift_op = ctrl_pkg::SFT_LUI;
                w.shift_srca_imm = 1'b1;
                w.out_sel = ctrl_pkg::OUT_SHIFT;
                w.reg_write = 1'b1;
            end
            isa_pkg::OP_LB, isa_pkg::OP_LH, isa_pkg::OP_LW, isa_pkg::OP_LBU,
            isa_pkg::OP_LHU, isa_pkg::OP_SB, isa_pkg::OP_SH, isa_pkg::OP_SW:
            begin
                case (op_v[1:0])
                    2'b00:   w.mem_size = ctrl_pkg::SZ_BYTE;
                    2'b01:   w.mem_size = ctrl_pkg::SZ_HALF;
                    default: w.mem_size = ctrl_pkg::SZ_WORD;
                endcase
                w.mem_req = 1'b1;
                w.mem_write = op_v[3];                           // Stores have bit 3 set
                w.imm_sign = 1'b1;
                w.reg_write = !op_v[3];
                w.mem_to_reg = !op_v[3];
                w.rdata_sign = !op_v[3] && !op_v[2];
            end
            default: w.reserved = 1'b1;
        endcase
        case (w.branch_cond)
            ctrl_pkg::BR_EQ:  cond = eq;
            ctrl_pkg::BR_NE:  cond = !eq;
            ctrl_pkg::BR_GTZ: cond = gt;
            ctrl_pkg::BR_LEZ: cond = !gt;
            ctrl_pkg::BR_GEZ, ctrl_pkg::BR_GEZAL: cond = gt || ez;
            default: cond = !gt && !ez;
        endcase
        taken = w.is_branch && cond;
        return w;
    endfunction

    task automatic check_ctrl(input string stage, input ctrl_pkg::ctrl_word_t want,
                              input ctrl_pkg::ctrl_word_t got);
        if (got !== want)
        begin
            $display("Error at %0t: %s control word expected %h, got %h",
                     $time, stage, want, got);
            $display("Test failed");
            $fatal(1, "control word mismatch");
        end
    endtask

    task automatic check_taken(input logic want, input logic got);
        if (got !== want)
        begin
            $display("Error at %0t: branch_taken expected %b, got %b", $time, want, got);
            $display("Test failed");
            $fatal(1, "branch_taken mismatch");
        end
    endtask

    task automatic drive_inputs(input int idx);
        logic [31:0] raw;
        int unsigned kind;
        raw = lcg_next();
        kind = pick(100);
        op = raw[31:26];                                         // Raw fields by default
        funct = raw[25:20];
        rt = raw[19:15];
        if (idx < N_SWEEP)
        begin
            // Each opcode, then each SPECIAL function, then each REGIMM branch
            if (idx < 24)
                op = OP_TAB[idx];
            else if (idx < 50)
            begin
                op = isa_pkg::OP_SPECIAL;
                funct = FN_TAB[idx-24];
            end
            else
            begin
                op = isa_pkg::OP_REGIMM;
                rt = RI_TAB[idx-50];
            end
        end
        else if (kind < 85)
        begin
            op = OP_TAB[pick(24)];
            funct = FN_TAB[pick(26)];
            rt = RI_TAB[pick(4)];
        end
        else if (kind < 88)
            op = 6'b010000;                                      // COP0
        else if (kind < 92)
        begin
            op = isa_pkg::OP_SPECIAL;
            funct = (kind < 90) ? 6'b001100 : 6'b001101;         // SYSCALL, BREAK
        end
        rs_eq_rt = (pick(2) == 0);
        rs_gt_zero = (pick(2) == 0);
        rs_eq_zero = (pick(2) == 0);
        stall_e = (idx >= FREE_RUN) && (pick(4) == 0);
        stall_m = (idx >= FREE_RUN) && (pick(4) == 0);
        stall_w = (idx >= FREE_RUN) && (pick(4) == 0);
        flush_e = (idx >= FREE_RUN) && (pick(6) == 0);
        flush_m = (idx >= FREE_RUN) && (pick(6) == 0);
        flush_w = (idx >= FREE_RUN) && (pick(6) == 0);
    endtask

    always_comb
        exp_d = ref_decode(op, funct, rt, rs_eq_rt, rs_gt_zero, rs_eq_zero, exp_taken);

    // Flush first, then stall, then load
    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            exp_e <= BUBBLE;
            exp_m <= BUBBLE;
            exp_w <= BUBBLE;
        end
        else
        begin
            exp_e <= flush_e ? BUBBLE : (stall_e ? exp_e : exp_d);
            exp_m <= flush_m ? BUBBLE : (stall_m ? exp_m : exp_e);
            exp_w <= flush_w ? BUBBLE : (stall_w ? exp_w : exp_m);
        end
    end

    // Sampled 1 ns before the rising edge
    always @(negedge clk)
    begin
        #4;
        check_ctrl("D", exp_d, d_ctrl);
        check_taken(exp_taken, branch_taken);
        check_ctrl("E", exp_e, e_ctrl);
        check_ctrl("M", exp_m, m_ctrl);
        check_ctrl("W", exp_w, w_ctrl);
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        seed = 32'h2f27_37a8;
        cycles = 0;
        clk = 1'b0;
        arst_n = 1'b0;
        op = '0;
        funct = '0;
        rt = '0;
        rs_eq_rt = 1'b0;
        rs_gt_zero = 1'b0;
        rs_eq_zero = 1'b0;
        stall_e = 1'b0;
        stall_m = 1'b0;
        stall_w = 1'b0;
        flush_e = 1'b0;
        flush_m = 1'b0;
        flush_w = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < N_TEST; i++)
        begin
            @(negedge clk);
            drive_inputs(i);
        end
        repeat (4) @(posedge clk);                               // Drain the last words
        $display("Test passed");
        $finish;
    end

endmodule

// ==== mips_ctrl.f ====
src/isa_pkg.sv
src/ctrl_pkg.sv
src/decode_unit.sv
src/ctrl_pipeline.sv
src/pipeline_controller.sv
verif/tb_pipeline_controller.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run with Verilator, then search the log for the fail message
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module tb_pipeline_controller \
    -f mips_ctrl.f -o tb_sim > sim.log 2>&1 && ./obj_dir/tb_sim >> sim.log 2>&1 \
    || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1
exit 0
